//--- filelist.f
+incdir+include
src/node_pkg.sv
src/stream_fifo.sv
src/stream_combiner.sv
src/stream_distributor.sv
src/node_router.sv
testbench/tb_node_router.sv

//--- include/node_defs.svh
// Build-time sizes of the mesh routing node
// Pulled in by the package and by any module that sizes port arrays
`ifndef NODE_DEFS_SVH
`define NODE_DEFS_SVH

// Width of one message payload
`define NODE_DATA_W 32

// Entries in each inbound FIFO
`define NODE_IN_DEPTH 4

// Entries in each outbound FIFO
`define NODE_OUT_DEPTH 4

// Outbound ports, one per direction
`define NODE_NUM_DIRS 4

`endif

//--- src/node_pkg.sv
// Shared types of the mesh routing node
// Imported by the combiner, the distributor and the top level
`default_nettype none

`include "node_defs.svh"

package node_pkg;

// Outbound direction doubles as the outbound port index
typedef enum logic [1:0] {
    NODE_DIR_NORTH = 2'd0,
    NODE_DIR_EAST  = 2'd1,
    NODE_DIR_SOUTH = 2'd2,
    NODE_DIR_WEST  = 2'd3
} node_dir_t;

// Payload of one message, also the outbound stream payload
typedef logic [`NODE_DATA_W-1:0] node_data_t;

// Inbound message with its steering field in the low bits
typedef struct packed {
    node_data_t data;
    node_dir_t  dir;
} node_msg_t;

// Combiner arbitration schemes
typedef enum logic [1:0] {
    NODE_ARB_RR       = 2'd0,
    NODE_ARB_PREFER_A = 2'd1,
    NODE_ARB_PREFER_B = 2'd2
} node_arb_t;

endpackage : node_pkg

`default_nettype wire

//--- src/node_router.sv
// Mesh node top level
// Inbound FIFOs feed the combiner and the distributor fans out to four outbound FIFOs
`timescale 1ns/1ps
`default_nettype none

`include "node_defs.svh"

module node_router import node_pkg::*; #(
      parameter node_arb_t ARB_SCHEME = NODE_ARB_RR
) (
      input  logic                               clk_i
    , input  logic                               rst_i
    // From the neighbouring node
    , input  node_msg_t                          a_msg_i
    , input  logic                               a_valid_i
    , output logic                               a_ready_o
    // From the local host
    , input  node_msg_t                          b_msg_i
    , input  logic                               b_valid_i
    , output logic                               b_ready_o
    // Outbound ports north, east, south, west
    , output node_data_t [`NODE_NUM_DIRS-1:0]    out_data_o
    , output logic       [`NODE_NUM_DIRS-1:0]    out_valid_o
    , input  logic       [`NODE_NUM_DIRS-1:0]    out_ready_i
);

// Buffered inbound streams
node_msg_t                        in_a_msg;
logic                             in_a_valid;
logic                             in_a_ready;
node_msg_t                        in_b_msg;
logic                             in_b_valid;
logic                             in_b_ready;

// Merged stream
node_msg_t                        comb_msg;
logic                             comb_valid;
logic                             comb_ready;

// Steered streams into the outbound FIFOs
node_data_t [`NODE_NUM_DIRS-1:0]  dist_data;
logic       [`NODE_NUM_DIRS-1:0]  dist_valid;
logic       [`NODE_NUM_DIRS-1:0]  dist_ready;

// Inbound buffering
stream_fifo #(
      .payload_t (node_msg_t)
    , .DEPTH     (`NODE_IN_DEPTH)
) u_in_fifo_a (
      .clk_i      (clk_i)
    , .rst_i      (rst_i)
    , .wr_data_i  (a_msg_i)
    , .wr_valid_i (a_valid_i)
    , .wr_ready_o (a_ready_o)
    , .rd_data_o  (in_a_msg)
    , .rd_valid_o (in_a_valid)
    , .rd_ready_i (in_a_ready)
);

stream_fifo #(
      .payload_t (node_msg_t)
    , .DEPTH     (`NODE_IN_DEPTH)
) u_in_fifo_b (
      .clk_i      (clk_i)
    , .rst_i      (rst_i)
    , .wr_data_i  (b_msg_i)
    , .wr_valid_i (b_valid_i)
    , .wr_ready_o (b_ready_o)
    , .rd_data_o  (in_b_msg)
    , .rd_valid_o (in_b_valid)
    , .rd_ready_i (in_b_ready)
);

// Arbitration between neighbour and host
stream_combiner #(
      .payload_t  (node_msg_t)
    , .ARB_SCHEME (ARB_SCHEME)
) u_combiner (
      .clk_i        (clk_i)
    , .rst_i        (rst_i)
    , .a_data_i     (in_a_msg)
    , .a_valid_i    (in_a_valid)
    , .a_ready_o    (in_a_ready)
    , .b_data_i     (in_b_msg)
    , .b_valid_i    (in_b_valid)
    , .b_ready_o    (in_b_ready)
    , .comb_data_o  (comb_msg)
    , .comb_valid_o (comb_valid)
    , .comb_ready_i (comb_ready)
);

// Direction steering
stream_distributor u_distributor (
      .in_msg_i    (comb_msg)
    , .in_valid_i  (comb_valid)
    , .in_ready_o  (comb_ready)
    , .out_data_o  (dist_data)
    , .out_valid_o (dist_valid)
    , .out_ready_i (dist_ready)
);

// Outbound buffering, one FIFO per port
generate
    for (genvar dir = 0; dir < `NODE_NUM_DIRS; dir++) begin : g_out
        stream_fifo #(
              .payload_t (node_data_t)
            , .DEPTH     (`NODE_OUT_DEPTH)
        ) u_out_fifo (
              .clk_i      (clk_i)
            , .rst_i      (rst_i)
            , .wr_data_i  (dist_data[dir])
            , .wr_valid_i (dist_valid[dir])
            , .wr_ready_o (dist_ready[dir])
            , .rd_data_o  (out_data_o[dir])
            , .rd_valid_o (out_valid_o[dir])
            , .rd_ready_i (out_ready_i[dir])
        );
    end
endgenerate

endmodule : node_router

`default_nettype wire

//--- src/stream_combiner.sv
// Merges two valid/ready streams into one
// Grant stays locked on a presented message until it is accepted
`timescale 1ns/1ps
`default_nettype none

module stream_combiner import node_pkg::*; #(
      parameter type       payload_t  = node_msg_t
    , parameter node_arb_t ARB_SCHEME = NODE_ARB_RR
) (
      input  logic     clk_i
    , input  logic     rst_i
    // Input stream A
    , input  payload_t a_data_i
    , input  logic     a_valid_i
    , output logic     a_ready_o
    // Input stream B
    , input  payload_t b_data_i
    , input  logic     b_valid_i
    , output logic     b_ready_o
    // Merged stream
    , output payload_t comb_data_o
    , output logic     comb_valid_o
    , input  logic     comb_ready_i
);

localparam logic GRANT_A = 1'b0;
localparam logic GRANT_B = 1'b1;

// Grant state
logic active;
logic last;
logic lock;

// Arbitration terms
logic next;
logic served;
logic hold;

// Only the granted input reaches the output
assign comb_data_o  = (active == GRANT_B) ? b_data_i  : a_data_i;
assign comb_valid_o = (active == GRANT_B) ? b_valid_i : a_valid_i;
assign a_ready_o    = comb_ready_i && (active == GRANT_A);
assign b_ready_o    = comb_ready_i && (active == GRANT_B);

// Message on the output that is not taken this cycle
assign hold = (lock || comb_valid_o) && !comb_ready_i;

// Input that moved a message most recently
assign served = (comb_valid_o && comb_ready_i) ? active : last;

// Next grant by scheme
always_comb begin
    case (ARB_SCHEME)
        NODE_ARB_PREFER_A: next = (!a_valid_i && b_valid_i) ? GRANT_B : GRANT_A;
        NODE_ARB_PREFER_B: next = b_valid_i ? GRANT_B : GRANT_A;
        default: begin
            // Round robin flips only under contention
            if (a_valid_i && b_valid_i) begin
                next = ~served;
            end else begin
                next = b_valid_i ? GRANT_B : GRANT_A;
            end
        end
    endcase
end

always_ff @(posedge clk_i or posedge rst_i) begin : p_arb
    if (rst_i) begin
        active <= GRANT_A;
        // A wins the first contention
        last   <= GRANT_B;
        lock   <= 1'b0;
    end else begin
        last <= served;
        lock <= hold;
        if (!hold) begin
            active <= next;
        end
    end
end

// Stalled output keeps valid and payload
a_out_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    (comb_valid_o && !comb_ready_i) |=> (comb_valid_o && $stable(comb_data_o)))
    else $error("Combiner output changed while stalled");

endmodule : stream_combiner

`default_nettype wire

//--- src/stream_distributor.sv
// Steers one message stream onto one of four outbound streams
// Selection comes from the direction field, which is dropped on the way out
`timescale 1ns/1ps
`default_nettype none

`include "node_defs.svh"

module stream_distributor import node_pkg::*; (
    // Merged message stream
      input  node_msg_t                          in_msg_i
    , input  logic                               in_valid_i
    , output logic                               in_ready_o
    // Outbound streams, indexed by direction
    , output node_data_t [`NODE_NUM_DIRS-1:0]    out_data_o
    , output logic       [`NODE_NUM_DIRS-1:0]    out_valid_o
    , input  logic       [`NODE_NUM_DIRS-1:0]    out_ready_i
);

// Port picked by the current message
node_dir_t sel_dir;

assign sel_dir = in_msg_i.dir;

// Same payload on every port
// Only the selected port sees valid
generate
    for (genvar dir = 0; dir < `NODE_NUM_DIRS; dir++) begin : g_data
        assign out_data_o[dir] = in_msg_i.data;
    end
endgenerate

// One-hot valid toward the selected port
always_comb begin
    out_valid_o          = '0;
    out_valid_o[sel_dir] = in_valid_i;
end

// Back-pressure from the selected port only
// Other ports stalling does not block this message
assign in_ready_o = out_ready_i[sel_dir];

// Never more than one port driven
always_comb begin
    a_onehot_valid : assert final ($onehot0(out_valid_o))
        else $error("Distributor drove more than one port");
end

endmodule : stream_distributor

`default_nettype wire

//--- src/stream_fifo.sv
// Valid/ready FIFO for any packed payload type
// Write side stalls while full, read side presents the oldest entry
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
      parameter type         payload_t = logic [31:0]
    , parameter int unsigned DEPTH     = 4
) (
      input  logic     clk_i
    , input  logic     rst_i
    // Producer side
    , input  payload_t wr_data_i
    , input  logic     wr_valid_i
    , output logic     wr_ready_o
    // Consumer side
    , output payload_t rd_data_o
    , output logic     rd_valid_o
    , input  logic     rd_ready_i
);

localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int unsigned CNT_W = $clog2(DEPTH + 1);

// Storage
payload_t         mem [DEPTH];

// Pointers and occupancy
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;

// Handshake completions
logic             wr_fire;
logic             rd_fire;

// Advance a pointer around the ring
function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
endfunction

// Flags straight from the count
assign wr_ready_o = (count != CNT_W'(DEPTH));
assign rd_valid_o = (count != '0);

// Head of queue read without a register stage
assign rd_data_o  = mem[rd_ptr];

assign wr_fire = wr_valid_i && wr_ready_o;
assign rd_fire = rd_valid_o && rd_ready_i;

// Payload store
always_ff @(posedge clk_i) begin
    if (wr_fire) begin
        mem[wr_ptr] <= wr_data_i;
    end
end

// Pointer and count update
always_ff @(posedge clk_i or posedge rst_i) begin : p_ctrl
    if (rst_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (wr_fire) begin
            wr_ptr <= ptr_inc(wr_ptr);
        end
        if (rd_fire) begin
            rd_ptr <= ptr_inc(rd_ptr);
        end
        // Simultaneous push and pop leaves the count alone
        if (wr_fire && !rd_fire) begin
            count <= count + 1'b1;
        end else if (rd_fire && !wr_fire) begin
            count <= count - 1'b1;
        end
    end
end

// Occupancy stays in range
a_count_range : assert property (@(posedge clk_i) disable iff (rst_i)
    count <= CNT_W'(DEPTH))
    else $error("FIFO count above depth");

// A full FIFO never grows
a_full_no_write : assert property (@(posedge clk_i) disable iff (rst_i)
    (count == CNT_W'(DEPTH)) |=> (count <= $past(count)))
    else $error("FIFO accepted a write while full");

// Producer keeps a stalled write steady
a_wr_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    (wr_valid_i && !wr_ready_o) |=> (wr_valid_i && $stable(wr_data_i)))
    else $error("Producer changed a stalled write");

endmodule : stream_fifo

`default_nettype wire

//--- testbench/tb_node_router.sv
// Self-checking testbench for the mesh routing node with round-robin arbitration
// Random traffic from both sources, then a contention phase toward one port
// Outputs are sampled on the falling edge against per-source, per-port queues
`timescale 1ns/1ps
`default_nettype none

`include "node_defs.svh"

module tb_node_router import node_pkg::*; ();

localparam int NUM_Q    = 2 * `NODE_NUM_DIRS;
localparam int Q_SIZE   = 256;
localparam int MSGS_RND = 200;
localparam int MSGS_CON = 32;

localparam int MODE_RANDOM  = 0;
localparam int MODE_DRAIN   = 1;
localparam int MODE_CONTEND = 2;

// DUT ports
logic                             clk_i = 1'b0;
logic                             rst_i;
node_msg_t                        a_msg_i;
logic                             a_valid_i;
logic                             a_ready_o;
node_msg_t                        b_msg_i;
logic                             b_valid_i;
logic                             b_ready_o;
node_data_t [`NODE_NUM_DIRS-1:0]  out_data_o;
logic       [`NODE_NUM_DIRS-1:0]  out_valid_o;
logic       [`NODE_NUM_DIRS-1:0]  out_ready_i;

// Stimulus control
integer                           seed;
int                               mode;
int                               a_left;
int                               b_left;
logic                             a_fire;
logic                             b_fire;

// Reference model, one ring per source and direction
node_data_t                       exp_mem [NUM_Q][Q_SIZE];
int                               exp_head [NUM_Q];
int                               exp_tail [NUM_Q];
int                               sent_total;
int                               recv_total;

// Stall tracking for the hold check
logic       [`NODE_NUM_DIRS-1:0]  stall;
node_data_t [`NODE_NUM_DIRS-1:0]  held;

// Fairness counters for the contention phase
logic                             track_balance;
int                               bal_a;
int                               bal_b;

int                               errors;
int                               checks;
logic                             ok;

node_router #(
    .ARB_SCHEME (NODE_ARB_RR)
) u_dut (
      .clk_i       (clk_i)
    , .rst_i       (rst_i)
    , .a_msg_i     (a_msg_i)
    , .a_valid_i   (a_valid_i)
    , .a_ready_o   (a_ready_o)
    , .b_msg_i     (b_msg_i)
    , .b_valid_i   (b_valid_i)
    , .b_ready_o   (b_ready_o)
    , .out_data_o  (out_data_o)
    , .out_valid_o (out_valid_o)
    , .out_ready_i (out_ready_i)
);

// 100 ns period
always #50 clk_i = ~clk_i;

task automatic check_data(input string name, input node_data_t got, input node_data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_valid(input string name, input logic [`NODE_NUM_DIRS-1:0] got,
                           input logic [`NODE_NUM_DIRS-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

// Source bit in the top payload bit
function automatic node_msg_t make_msg(input logic src, input node_dir_t dir,
                                       input logic [31:0] rnd);
    node_msg_t msg;
    msg.data                  = rnd;
    msg.data[`NODE_DATA_W-1] = src;
    msg.dir                   = dir;
    return msg;
endfunction

task automatic push_expected(input logic src, input node_msg_t msg);
    int qi;
    qi = src * `NODE_NUM_DIRS + int'(msg.dir);
    exp_mem[qi][exp_tail[qi] % Q_SIZE] = msg.data;
    exp_tail[qi]++;
    sent_total++;
endtask

// Queue picked by the port and the source bit
task automatic pop_and_compare(input int port, input node_data_t data);
    logic src;
    int   qi;
    src = data[`NODE_DATA_W-1];
    qi  = src * `NODE_NUM_DIRS + port;
    recv_total++;
    if (track_balance) begin
        if (src) bal_b++;
        else bal_a++;
    end
    if (exp_head[qi] == exp_tail[qi]) begin
        errors++;
        $display("Error: port %0d delivered %h but no such message was pending", port, data);
    end else begin
        check_data($sformatf("out_data_o[%0d]", port), data,
                   exp_mem[qi][exp_head[qi] % Q_SIZE]);
        exp_head[qi]++;
    end
endtask

function automatic logic queues_empty();
    for (int i = 0; i < NUM_Q; i++) begin
        if (exp_head[i] != exp_tail[i]) return 1'b0;
    end
    return 1'b1;
endfunction

// All stimulus on the rising edge, one random stream
always @(posedge clk_i) begin : p_drive
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    logic [31:0] rnd_r;
    if (!rst_i) begin
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        rnd_r = $random(seed);
        // New offer only once the previous one has gone
        if (!a_valid_i || a_fire) begin
            if (a_left > 0 && (mode == MODE_CONTEND || rnd_a[30])) begin
                a_msg_i   <= make_msg(1'b0, (mode == MODE_CONTEND) ? NODE_DIR_EAST :
                                      node_dir_t'(rnd_a[1:0]), $random(seed));
                a_valid_i <= 1'b1;
                a_left = a_left - 1;
            end else begin
                a_valid_i <= 1'b0;
            end
        end
        if (!b_valid_i || b_fire) begin
            if (b_left > 0 && (mode == MODE_CONTEND || rnd_b[30])) begin
                b_msg_i   <= make_msg(1'b1, (mode == MODE_CONTEND) ? NODE_DIR_EAST :
                                      node_dir_t'(rnd_b[1:0]), $random(seed));
                b_valid_i <= 1'b1;
                b_left = b_left - 1;
            end else begin
                b_valid_i <= 1'b0;
            end
        end
        out_ready_i <= (mode == MODE_RANDOM) ? rnd_r[`NODE_NUM_DIRS-1:0] : '1;
    end
end

// Falling-edge monitor, sees the values that the next rising edge will transfer
always @(negedge clk_i) begin : p_monitor
    if (rst_i) begin
        check_valid("out_valid_o", out_valid_o, '0);
        check_flag("a_ready_o", a_ready_o, 1'b1);
        check_flag("b_ready_o", b_ready_o, 1'b1);
        a_fire = 1'b0;
        b_fire = 1'b0;
        stall  = '0;
    end else begin
        // Stalled outputs keep valid and payload
        check_valid("out_valid_o", out_valid_o & stall, stall);
        for (int p = 0; p < `NODE_NUM_DIRS; p++) begin
            if (stall[p]) check_data($sformatf("out_data_o[%0d]", p), out_data_o[p], held[p]);
        end
        a_fire = a_valid_i && a_ready_o;
        b_fire = b_valid_i && b_ready_o;
        if (a_fire) push_expected(1'b0, a_msg_i);
        if (b_fire) push_expected(1'b1, b_msg_i);
        for (int p = 0; p < `NODE_NUM_DIRS; p++) begin
            if (out_valid_o[p] && out_ready_i[p]) pop_and_compare(p, out_data_o[p]);
        end
        stall = out_valid_o & ~out_ready_i;
        held  = out_data_o;
        if (track_balance && (bal_a > bal_b + 1 || bal_b > bal_a + 1)) begin
            errors++;
            $display("Error: sources out of balance, A delivered %0d and B %0d", bal_a, bal_b);
        end
    end
end

task automatic wait_sources_done(input int limit, output logic done);
    int cycles;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < limit) begin
        @(negedge clk_i);
        cycles++;
        done = (a_left == 0) && (b_left == 0) && !a_valid_i && !b_valid_i;
    end
    if (!done) begin
        errors++;
        $display("Error: sources did not finish sending within %0d cycles", limit);
    end
endtask

task automatic wait_drained(input int limit, output logic done);
    int cycles;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < limit) begin
        @(negedge clk_i);
        cycles++;
        done = queues_empty() && (out_valid_o == '0);
    end
    if (!done) begin
        errors++;
        $display("Error: node did not drain within %0d cycles", limit);
    end
endtask

initial begin : p_main
    seed          = 32'h00c7_526e;
    errors        = 0;
    checks        = 0;
    sent_total    = 0;
    recv_total    = 0;
    mode          = MODE_RANDOM;
    a_left        = 0;
    b_left        = 0;
    a_fire        = 1'b0;
    b_fire        = 1'b0;
    stall         = '0;
    held          = '0;
    track_balance = 1'b0;
    bal_a         = 0;
    bal_b         = 0;
    for (int i = 0; i < NUM_Q; i++) begin
        exp_head[i] = 0;
        exp_tail[i] = 0;
    end
    rst_i       = 1'b1;
    a_msg_i     = '0;
    a_valid_i   = 1'b0;
    b_msg_i     = '0;
    b_valid_i   = 1'b0;
    out_ready_i = '0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    // Idle node right after reset
    @(negedge clk_i);
    check_valid("out_valid_o", out_valid_o, '0);
    check_flag("a_ready_o", a_ready_o, 1'b1);
    check_flag("b_ready_o", b_ready_o, 1'b1);

    // Random traffic with random back-pressure
    a_left = MSGS_RND;
    b_left = MSGS_RND;
    wait_sources_done(20000, ok);
    if (ok) begin
        mode = MODE_DRAIN;
        wait_drained(2000, ok);
    end

    // Both sources hammer the east port
    if (ok) begin
        bal_a         = 0;
        bal_b         = 0;
        track_balance = 1'b1;
        mode          = MODE_CONTEND;
        a_left        = MSGS_CON;
        b_left        = MSGS_CON;
        wait_sources_done(2000, ok);
    end
    if (ok) begin
        mode = MODE_DRAIN;
        wait_drained(2000, ok);
        track_balance = 1'b0;
    end

    // Nothing extra shows up once empty
    if (ok) begin
        repeat (10) begin
            @(negedge clk_i);
            check_valid("out_valid_o", out_valid_o, '0);
        end
        checks++;
        if (recv_total != sent_total || sent_total != 2 * (MSGS_RND + MSGS_CON)) begin
            errors++;
            $display("Error: %0d messages accepted, %0d delivered", sent_total, recv_total);
        end
    end

    $display("Checks: %0d, errors: %0d, messages: %0d sent, %0d received",
             checks, errors, sent_total, recv_total);
    if (errors == 0) begin
        $display("TEST OK");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule : tb_node_router

`default_nettype wire
